//--- dv/core_tests.txt
# T <name> | I <hex word> [repeat count] | R <reg> <hex value> | E <cause> <hex epc>
# cause 1 illegal, 2 overflow, 3 misaligned; every program ends on an undefined word
T alu_chain
I 20010005
I 20220007
I 00221820
I 00612022
I 00612824
I 00A43025
I 0026382A
I 2008FFFD
I 0101482A
I 00265022
I FC000000
R 1 00000005
R 2 0000000C
R 3 00000011
R 4 0000000C
R 5 00000001
R 6 0000000D
R 7 00000001
R 8 FFFFFFFD
R 9 00000001
R 10 FFFFFFF8
E 1 00000028
T store_load
I 20011234
I 20020008
I AC410004
I 8C430004
I 00632020
I AC040000
I 8C050000
I 20A60001
I FC000000
R 1 00001234
R 3 00001234
R 4 00002468
R 5 00002468
R 6 00002469
E 1 00000020
T branches
I 20010003
I 20020003
I 10220002
I 20030063
I 20040063
I 20050007
I 10250001
I 2006000B
I 10000001
I 20070037
I 20C80001
I FC000000
R 3 00000000
R 4 00000000
R 5 00000007
R 6 0000000B
R 7 00000000
R 8 0000000C
E 1 0000002C
T add_overflow
I 20010009
I 20024000
I 00421020 16
I 00421820
I 20040001
I FC000000
R 1 00000009
R 2 40000000
R 3 00000000
R 4 00000000
E 2 00000048
T lw_misaligned
I 20010006
I 8C220000
I 20030001
I FC000000
R 1 00000006
R 2 00000000
R 3 00000000
E 3 00000004
T zero_register
I 2000004D
I 20010005
I 00210020
I 00011020
I FC000000
R 0 00000000
R 1 00000005
R 2 00000005
E 1 00000010

//--- tb.f
logic/mips_pkg.sv
logic/instr_fetch.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_commit_stage.sv
logic/mips_core.sv
dv/mips_checker.sv
dv/tb_clock_gen.sv
dv/tb_monitor.sv
dv/tb_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+100
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_top.sv
// runs every program of dv/core_tests.txt from reset; start the simulation in the project root
`timescale 1ns/1ps

module tb_top
    import mips_pkg::*;
();

    localparam int IMEM_AW   = 6;
    localparam int DMEM_AW   = 6;
    localparam int MAX_WORDS = 2**IMEM_AW;
    localparam int MAX_EXP   = 16;

    logic                  SYS_clk;
    logic                  SYS_reset;
    logic                  run;
    logic                  prog_we;
    logic [IMEM_AW-1:0]    prog_addr;
    logic [XLEN-1:0]       prog_data;
    logic [REG_ADDR_W-1:0] dbg_addr;
    logic [XLEN-1:0]       dbg_data;
    logic                  halted;
    cause_t                exc_cause;
    logic [XLEN-1:0]       epc;

    logic [XLEN-1:0]       words [MAX_WORDS];
    logic [REG_ADDR_W-1:0] exp_reg [MAX_EXP];
    logic [XLEN-1:0]       exp_val [MAX_EXP];
    cause_t                exp_cause;
    logic [XLEN-1:0]       exp_epc;
    string                 test_name;
    int                    n_words;
    int                    n_exp;
    int                    n_pass;
    int                    n_fail;
    bit                    have_test;
    bit                    format_error;

    tb_clock_gen #(.PERIOD_NS(40)) clk0 (.SYS_clk(SYS_clk));

    mips_core #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) dut0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .halted    (halted),
        .exc_cause (exc_cause),
        .epc       (epc)
    );

    tb_monitor #(.MAX_EXP(MAX_EXP)) mon0 (
        .SYS_clk   (SYS_clk),
        .halted    (halted),
        .exc_cause (exc_cause),
        .epc       (epc),
        .dbg_data  (dbg_data),
        .dbg_addr  (dbg_addr)
    );

    // undefined opcode 0x3f with the word address in the low bits
    function automatic logic [XLEN-1:0] fill_word(input int addr);
        return {6'h3f, 26'(addr)};
    endfunction

    task automatic apply_reset();
        @(negedge SYS_clk);
        SYS_reset = 1'b1;
        run       = 1'b0;
        repeat (2) @(posedge SYS_clk);
        @(negedge SYS_clk);
        SYS_reset = 1'b0;
    endtask

    // whole imem is written so no word of an earlier program survives
    task automatic load_program();
        for (int a = 0; a < MAX_WORDS; a++)
        begin
            @(negedge SYS_clk);
            prog_we   = 1'b1;
            prog_addr = a[IMEM_AW-1:0];
            prog_data = (a < n_words) ? words[a] : fill_word(a);
        end
        @(negedge SYS_clk);
        prog_we = 1'b0;
    endtask

    task automatic run_test();
        bit ok;
        apply_reset();
        load_program();
        run = 1'b1;    // still on the falling edge
        mon0.check_test(test_name, n_exp, exp_reg, exp_val, exp_cause, exp_epc, ok);
        @(negedge SYS_clk);
        run = 1'b0;
        if (ok)
            n_pass++;
        else
            n_fail++;
    endtask

    task automatic parse_line(input string line);
        string           tag;
        logic [XLEN-1:0] word;
        int              num;
        int              reps;
        int              n;
        bit              bad;
        bad = 1'b0;
        n = $sscanf(line, "%s", tag);
        if (n < 1 || tag == "#")
            return;
        if (tag == "T")
        begin
            if (have_test)
                run_test();
            n_words   = 0;
            n_exp     = 0;
            exp_cause = CAUSE_NONE;
            exp_epc   = '0;
            have_test = 1'b1;
            n = $sscanf(line, "%s %s", tag, test_name);
        end
        else if (tag == "I")
        begin
            n = $sscanf(line, "%s %h %d", tag, word, reps);
            if (n < 3)
                reps = 1;    // repeat count is optional
            repeat (reps)
            begin
                if (n_words < MAX_WORDS)
                    words[n_words] = word;
                else
                    bad = 1'b1;
                n_words++;
            end
        end
        else if (tag == "R" && n_exp < MAX_EXP)
        begin
            n = $sscanf(line, "%s %d %h", tag, num, word);
            if (n < 3)
                bad = 1'b1;
            exp_reg[n_exp] = num[REG_ADDR_W-1:0];
            exp_val[n_exp] = word;
            n_exp++;
        end
        else if (tag == "E")
        begin
            n = $sscanf(line, "%s %d %h", tag, num, word);
            if (n < 3)
                bad = 1'b1;
            exp_cause = cause_t'(num[1:0]);
            exp_epc   = word;
        end
        else
            bad = 1'b1;
        if (bad)
        begin
            format_error = 1'b1;
            $display("tests file has a bad or oversized record: %s", line);
        end
    endtask

    initial
    begin
        int    fd;
        int    code;
        string line;
        SYS_reset    = 1'b1;
        run          = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        n_pass       = 0;
        n_fail       = 0;
        have_test    = 1'b0;
        format_error = 1'b0;
        fd = $fopen("dv/core_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open dv/core_tests.txt");
            format_error = 1'b1;
        end
        else
        begin
            code = $fgets(line, fd);
            while (code > 0)
            begin
                parse_line(line);
                code = $fgets(line, fd);
            end
            $fclose(fd);
            if (have_test)
                run_test();
        end
        if (dut0.chk0.assert_fails != 0)
            $display("%0d assertion failures in the checker", dut0.chk0.assert_fails);
        $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0 && !format_error && dut0.chk0.assert_fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- dv/tb_monitor.sv
// registers are read through the debug port only after halted, when no writeback is left
`timescale 1ns/1ps

module tb_monitor
    import mips_pkg::*;
#(
    parameter int MAX_EXP      = 16,
    parameter int HALT_TIMEOUT = 2000    // cycles from run to halted
)
(
    input  logic                  SYS_clk,
    input  logic                  halted,
    input  cause_t                exc_cause,
    input  logic [XLEN-1:0]       epc,
    input  logic [XLEN-1:0]       dbg_data,
    output logic [REG_ADDR_W-1:0] dbg_addr
);

    initial
        dbg_addr = '0;

    task automatic compare_value(
        input  string           name,
        input  string           what,
        input  logic [XLEN-1:0] expected,
        input  logic [XLEN-1:0] actual,
        inout  int              errors
    );
        if (actual !== expected)
        begin
            $display("FAILED %s: %s expected %h actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    // called at a falling edge just after run rose
    task automatic check_test(
        input  string                 name,
        input  int                    n_exp,
        input  logic [REG_ADDR_W-1:0] exp_reg [MAX_EXP],
        input  logic [XLEN-1:0]       exp_val [MAX_EXP],
        input  cause_t                exp_cause,
        input  logic [XLEN-1:0]       exp_epc,
        output bit                    ok
    );
        int              cycles;
        int              errors;
        logic [XLEN-1:0] value;
        cycles = 0;
        errors = 0;
        while (!halted && cycles < HALT_TIMEOUT)
        begin
            @(negedge SYS_clk);
            cycles++;
        end
        if (!halted)
        begin
            $display("%s: core did not halt within %0d cycles", name, HALT_TIMEOUT);
            ok = 1'b0;
            return;
        end
        compare_value(name, "cause", XLEN'(exp_cause), XLEN'(exc_cause), errors);
        compare_value(name, "epc", exp_epc, epc, errors);
        for (int i = 0; i < n_exp; i++)
        begin
            dbg_addr = exp_reg[i];    // set on the falling edge
            @(posedge SYS_clk);
            value = dbg_data;
            compare_value(name, $sformatf("r%0d", exp_reg[i]), exp_val[i], value, errors);
            @(negedge SYS_clk);
        end
        ok = (errors == 0);
        if (ok)
            $display("PASS %s after %0d cycles", name, cycles);
        else
            $display("%s: %0d mismatches", name, errors);
    endtask

endmodule

//--- dv/tb_clock_gen.sv
// free-running SYS_clk that starts low, the period is given in whole nanoseconds
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int PERIOD_NS = 40
)
(
    output logic SYS_clk
);

    initial
    begin
        SYS_clk = 1'b0;
        forever #(PERIOD_NS / 2) SYS_clk = ~SYS_clk;    // half period per phase
    end

endmodule

//--- dv/mips_checker.sv
// watches only the status outputs of the core and is bound into every mips_core
`timescale 1ns/1ps

module mips_checker
    import mips_pkg::*;
(
    input logic            SYS_clk,
    input logic            SYS_reset,
    input logic            halted,
    input cause_t          exc_cause,
    input logic [XLEN-1:0] epc
);

    int assert_fails = 0;    // read by tb_top at the end of the run

    halt_sticky: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        $past(halted) |-> halted)
    else
    begin
        assert_fails++;
        $error("halted fell while reset was low");
    end

    cause_idle: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !halted |-> (exc_cause == CAUSE_NONE))
    else
    begin
        assert_fails++;
        $error("exception cause is set while the core is not halted");
    end

    epc_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        epc[1:0] == 2'b00)
    else
    begin
        assert_fails++;
        $error("exception pc is not word aligned");
    end

endmodule

bind mips_core mips_checker chk0 (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .halted    (halted),
    .exc_cause (exc_cause),
    .epc       (epc)
);

//--- logic/mips_core.sv
// load the program while run is low, then raise run and wait for halted
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
#(
    parameter int IMEM_AW = 6,
    parameter int DMEM_AW = 6
)
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  run,
    input  logic                  prog_we,
    input  logic [IMEM_AW-1:0]    prog_addr,
    input  logic [XLEN-1:0]       prog_data,
    input  logic [REG_ADDR_W-1:0] dbg_addr,
    output logic [XLEN-1:0]       dbg_data,
    output logic                  halted,
    output cause_t                exc_cause,
    output logic [XLEN-1:0]       epc
);

    logic                  fetch_valid;
    logic [XLEN-1:0]       fetch_pc;
    logic [XLEN-1:0]       fetch_instr;
    logic                  stall;
    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target;
    logic                  flush;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    id_ex_t                id_ex;
    ex_dest_t              ex_dest;
    ex_mem_t               ex_mem;
    mem_wb_t               mem_wb;

    instr_fetch #(.IMEM_AW(IMEM_AW)) fetch0 (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .run           (run),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .flush         (flush),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_instr   (fetch_instr)
    );

    reg_file regs0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .dbg_addr  (dbg_addr),
        .mem_wb    (mem_wb),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .dbg_data  (dbg_data)
    );

    decode_stage decode0 (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .flush         (flush),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_instr   (fetch_instr),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .ex_dest       (ex_dest),
        .ex_mem        (ex_mem),
        .rs_addr       (rs_addr),
        .rt_addr       (rt_addr),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_ex         (id_ex)
    );

    execute_stage exec0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .flush     (flush),
        .id_ex     (id_ex),
        .ex_dest   (ex_dest),
        .ex_mem    (ex_mem)
    );

    mem_commit_stage #(.DMEM_AW(DMEM_AW)) commit0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .flush     (flush),
        .halted    (halted),
        .exc_cause (exc_cause),
        .epc       (epc)
    );

endmodule

//--- logic/mem_commit_stage.sv
// the first excepting instruction halts the core until reset; data memory has no reset
`timescale 1ns/1ps

module mem_commit_stage
    import mips_pkg::*;
#(
    parameter int DMEM_AW = 6
)
(
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    input  ex_mem_t         ex_mem,
    output mem_wb_t         mem_wb,
    output logic            flush,
    output logic            halted,
    output cause_t          exc_cause,
    output logic [XLEN-1:0] epc
);

    logic [XLEN-1:0]    dmem [2**DMEM_AW];
    logic [DMEM_AW-1:0] word_addr;
    logic [XLEN-1:0]    load_data;
    logic               live;
    logic               commit_ok;

    assign live      = ex_mem.valid && !halted;
    assign commit_ok = live && (ex_mem.cause == CAUSE_NONE);
    assign flush     = live && (ex_mem.cause != CAUSE_NONE);

    assign word_addr = ex_mem.alu_result[DMEM_AW+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge SYS_clk)
    begin
        if (commit_ok && ex_mem.ctrl.mem_write)
            dmem[word_addr] <= ex_mem.store_data;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            halted    <= 1'b0;
            exc_cause <= CAUSE_NONE;
            epc       <= '0;
        end
        else if (flush)
        begin
            halted    <= 1'b1;
            exc_cause <= ex_mem.cause;
            epc       <= ex_mem.pc;     // faulting instruction
        end
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            mem_wb <= '0;
        else
        begin
            mem_wb.valid     <= commit_ok;
            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
            mem_wb.dest      <= ex_mem.dest;
            mem_wb.wdata     <= ex_mem.ctrl.mem_read ? load_data : ex_mem.alu_result;
        end
    end

endmodule

//--- logic/execute_stage.sv
// an older cause from decode wins over overflow, and overflow wins over a misaligned address
`timescale 1ns/1ps

module execute_stage
    import mips_pkg::*;
(
    input  logic     SYS_clk,
    input  logic     SYS_reset,
    input  logic     flush,
    input  id_ex_t   id_ex,
    output ex_dest_t ex_dest,
    output ex_mem_t  ex_mem
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu_result;
    logic            ovf_add;
    logic            ovf_sub;
    logic            overflow;
    logic            misaligned;
    cause_t          cause;

    assign a = id_ex.op_a;
    assign b = id_ex.op_b;

    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_result = a - b;
            ALU_AND: alu_result = a & b;
            ALU_OR:  alu_result = a | b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: alu_result = a + b;
        endcase
    end

    // sign of the result disagrees with the operands
    assign ovf_add  = (a[XLEN-1] == b[XLEN-1]) && (alu_result[XLEN-1] != a[XLEN-1]);
    assign ovf_sub  = (a[XLEN-1] != b[XLEN-1]) && (alu_result[XLEN-1] != a[XLEN-1]);
    assign overflow = id_ex.ctrl.check_ovf
                      && ((id_ex.ctrl.alu_op == ALU_SUB) ? ovf_sub : ovf_add);

    assign misaligned = (id_ex.ctrl.mem_read || id_ex.ctrl.mem_write)
                        && (alu_result[1:0] != 2'b00);

    always_comb
    begin
        if (id_ex.cause != CAUSE_NONE)
            cause = id_ex.cause;
        else if (overflow)
            cause = CAUSE_OVERFLOW;
        else if (misaligned)
            cause = CAUSE_MISALIGNED;
        else
            cause = CAUSE_NONE;
    end

    assign ex_dest.valid     = id_ex.valid;
    assign ex_dest.reg_write = id_ex.ctrl.reg_write;
    assign ex_dest.dest      = id_ex.dest;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_mem <= '0;
        else if (flush)
            ex_mem <= '0;
        else
        begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.pc         <= id_ex.pc;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= id_ex.store_data;
            ex_mem.dest       <= id_ex.dest;
            ex_mem.cause      <= cause;
        end
    end

endmodule

//--- logic/decode_stage.sv
// no forwarding, so decode waits until a producer reaches writeback; beq also waits on the interlock
`timescale 1ns/1ps

module decode_stage
    import mips_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  flush,
    input  logic                  fetch_valid,
    input  logic [XLEN-1:0]       fetch_pc,
    input  logic [XLEN-1:0]       fetch_instr,
    input  logic [XLEN-1:0]       rs_data,
    input  logic [XLEN-1:0]       rt_data,
    input  ex_dest_t              ex_dest,
    input  ex_mem_t               ex_mem,
    output logic [REG_ADDR_W-1:0] rs_addr,
    output logic [REG_ADDR_W-1:0] rt_addr,
    output logic                  stall,
    output logic                  branch_taken,
    output logic [XLEN-1:0]       branch_target,
    output id_ex_t                id_ex
);

    opcode_t               opcode;
    funct_t                funct;
    ctrl_t                 ctrl;
    logic                  illegal;
    logic                  uses_rt;
    logic                  is_beq;
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       imm;

    assign opcode  = opcode_t'(fetch_instr[31:26]);
    assign funct   = funct_t'(fetch_instr[5:0]);
    assign rs_addr = fetch_instr[25:21];
    assign rt_addr = fetch_instr[20:16];
    assign imm     = {{(XLEN-16){fetch_instr[15]}}, fetch_instr[15:0]};

    always_comb
    begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;      // lw, sw and addi add
        illegal     = 1'b0;
        uses_rt     = 1'b0;
        is_beq      = 1'b0;
        dest        = fetch_instr[20:16];
        case (opcode)
            OP_RTYPE:
            begin
                dest           = fetch_instr[15:11];
                uses_rt        = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    F_ADD: ctrl.check_ovf = 1'b1;
                    F_SUB:
                    begin
                        ctrl.alu_op    = ALU_SUB;
                        ctrl.check_ovf = 1'b1;
                    end
                    F_AND:   ctrl.alu_op = ALU_AND;
                    F_OR:    ctrl.alu_op = ALU_OR;
                    F_SLT:   ctrl.alu_op = ALU_SLT;
                    default: illegal = 1'b1;
                endcase
            end
            OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.check_ovf   = 1'b1;
            end
            OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                uses_rt          = 1'b1;    // store data
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BEQ:
            begin
                uses_rt = 1'b1;
                is_beq  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal)
        begin
            ctrl    = '0;
            uses_rt = 1'b0;
        end
    end

    // a valid writer in execute or memory that has not reached writeback yet
    function automatic logic pending(input logic [REG_ADDR_W-1:0] addr);
        logic in_ex;
        logic in_mem;
        in_ex  = ex_dest.valid && ex_dest.reg_write && (ex_dest.dest == addr);
        in_mem = ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.dest == addr);
        return (addr != '0) && (in_ex || in_mem);
    endfunction

    always_comb
    begin
        stall = fetch_valid && !illegal
                && (pending(rs_addr) || (uses_rt && pending(rt_addr)));
    end

    assign branch_taken  = fetch_valid && is_beq && !stall && (rs_data == rt_data);
    assign branch_target = fetch_pc + XLEN'(4) + {imm[XLEN-3:0], 2'b00};

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            id_ex <= '0;
        else if (flush || stall || !fetch_valid)
            id_ex <= '0;    // bubble
        else
        begin
            id_ex.valid      <= 1'b1;
            id_ex.pc         <= fetch_pc;
            id_ex.ctrl       <= ctrl;
            id_ex.op_a       <= rs_data;
            id_ex.op_b       <= ctrl.alu_src_imm ? imm : rt_data;
            id_ex.store_data <= rt_data;
            id_ex.dest       <= dest;
            id_ex.cause      <= illegal ? CAUSE_ILLEGAL : CAUSE_NONE;
        end
    end

endmodule

//--- logic/reg_file.sv
// register 0 reads as zero and ignores writes, and every port sees a same-cycle write
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic [REG_ADDR_W-1:0] rs_addr,
    input  logic [REG_ADDR_W-1:0] rt_addr,
    input  logic [REG_ADDR_W-1:0] dbg_addr,
    input  mem_wb_t               mem_wb,
    output logic [XLEN-1:0]       rs_data,
    output logic [XLEN-1:0]       rt_data,
    output logic [XLEN-1:0]       dbg_data
);

    logic [XLEN-1:0] regs [1:31];
    logic            wr_en;

    assign wr_en = mem_wb.valid && mem_wb.reg_write && (mem_wb.dest != '0);

    // write-through read covers the writeback hazard
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] value;
        if (addr == '0)
            value = '0;
        else if (wr_en && (mem_wb.dest == addr))
            value = mem_wb.wdata;
        else
            value = regs[addr];
        return value;
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[mem_wb.dest] <= mem_wb.wdata;
    end

    always_comb
    begin
        rs_data  = read_reg(rs_addr);
        rt_data  = read_reg(rt_addr);
        dbg_data = read_reg(dbg_addr);
    end

endmodule

//--- logic/instr_fetch.sv
// program load is only safe while run is low, and the pc wraps inside the instruction memory
`timescale 1ns/1ps

module instr_fetch
    import mips_pkg::*;
#(
    parameter int IMEM_AW = 6
)
(
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               run,
    input  logic               prog_we,
    input  logic [IMEM_AW-1:0] prog_addr,
    input  logic [XLEN-1:0]    prog_data,
    input  logic               stall,
    input  logic               branch_taken,
    input  logic [XLEN-1:0]    branch_target,
    input  logic               flush,
    output logic               fetch_valid,
    output logic [XLEN-1:0]    fetch_pc,
    output logic [XLEN-1:0]    fetch_instr
);

    logic [XLEN-1:0] imem [2**IMEM_AW];
    logic [XLEN-1:0] pc;

    always_ff @(posedge SYS_clk)
    begin
        if (prog_we)
            imem[prog_addr] <= prog_data;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc          <= RESET_PC;
            fetch_valid <= 1'b0;
            fetch_pc    <= '0;
            fetch_instr <= '0;
        end
        else if (!run)
        begin
            pc          <= RESET_PC;    // idle pipeline holds bubbles
            fetch_valid <= 1'b0;
        end
        else if (flush)
            fetch_valid <= 1'b0;        // pc holds
        else if (branch_taken)
        begin
            pc          <= branch_target;
            fetch_valid <= 1'b0;        // squash the word behind the beq
        end
        else if (!stall)
        begin
            pc          <= pc + XLEN'(4);
            fetch_valid <= 1'b1;
            fetch_pc    <= pc;
            fetch_instr <= imem[pc[IMEM_AW+1:2]];
        end
    end

endmodule

//--- logic/mips_pkg.sv
// word-only memories, nine instructions decode and every other encoding raises the illegal cause
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        CAUSE_NONE       = 2'd0,
        CAUSE_ILLEGAL    = 2'd1,
        CAUSE_OVERFLOW   = 2'd2,
        CAUSE_MISALIGNED = 2'd3
    } cause_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;    // operand b is the immediate
        alu_op_t alu_op;
        logic    check_ovf;      // add, sub and addi trap on overflow
    } ctrl_t;

    // destination of the instruction in execute, for the decode interlock
    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] dest;
    } ex_dest_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;          // rt or immediate, already selected
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] dest;
        cause_t                cause;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] dest;
        cause_t                cause;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       wdata;
    } mem_wb_t;

endpackage
